/* build.f */
+incdir+verification
rtl/normCorrPkg.sv
rtl/sampleStore.sv
rtl/excConvolver.sv
rtl/lagCorrelator.sv
rtl/excfUpdater.sv
rtl/lagSequencer.sv
rtl/normCorrTop.sv
verification/normCorrTb.sv

/* Bender.yml */
package:
  name: normCorr

sources:
  - rtl/normCorrPkg.sv
  - rtl/sampleStore.sv
  - rtl/excConvolver.sv
  - rtl/lagCorrelator.sv
  - rtl/excfUpdater.sv
  - rtl/lagSequencer.sv
  - rtl/normCorrTop.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/normCorrTb.sv

/* verification/normCorrModel.svh */
`ifndef NORMCORRMODEL_SVH
`define NORMCORRMODEL_SVH

//////////////////////////////////////////////////
// Reference model of the pitch correlation terms
//////////////////////////////////////////////////
localparam longint AccHigh = 64'sd2147483647;
localparam longint AccLow = -64'sd2147483648;

longint modelMem [0:511]; // Mirror of every loaded word
longint modelExcf [0:63];
normCorrPkg::lagResult_t expected [$];

// Wide integer arithmetic, clamped to the 32-bit range
function automatic longint clampAcc(longint v);
	if (v > AccHigh)
		return AccHigh;
	if (v < AccLow)
		return AccLow;
	return v;
endfunction

function automatic longint dblProd(longint a, longint b);
	return clampAcc(2 * a * b);
endfunction

function automatic longint macSat(longint acc, longint a, longint b);
	return clampAcc(acc + dblProd(a, b));
endfunction

function automatic longint shlSat(longint x, int n);
	return clampAcc(x * (64'sd1 << n));
endfunction

function automatic longint highPart(longint x);
	return x >>> 16; // Floor, same as the top 16 bits
endfunction

function automatic longint addSat16(longint a, longint b);
	if (a + b > 32767)
		return 32767;
	if (a + b < -32768)
		return -32768;
	return a + b;
endfunction

// Appends one expected result per lag from first to last
task automatic predictRun(input int first, input int last);
	int zero;
	int hBase;
	int xnBase;
	longint sum;
	longint energy;
	longint corr;
	longint excK;
	longint term;
	normCorrPkg::lagResult_t r;
	zero = int'(normCorrPkg::ExcZero);
	hBase = int'(normCorrPkg::HBase);
	xnBase = int'(normCorrPkg::XnBase);
	for (int n = 0; n < SubframeLen; n++)
	begin
		sum = 0;
		for (int i = 0; i <= n; i++)
			sum = macSat(sum, modelMem[zero - first + i], modelMem[hBase + n - i]);
		modelExcf[n] = highPart(shlSat(sum, normCorrPkg::ConvShift));
	end
	for (int lag = first; lag <= last; lag++)
	begin
		energy = 0;
		corr = 0;
		for (int j = 0; j < SubframeLen; j++)
		begin
			energy = macSat(energy, modelExcf[j], modelExcf[j]);
			corr = macSat(corr, modelMem[xnBase + j], modelExcf[j]);
		end
		r.lag = normCorrPkg::lag_t'(lag);
		r.corr = normCorrPkg::acc_t'(corr);
		r.energy = normCorrPkg::acc_t'(energy);
		expected.push_back(r);
		if (lag < last)
		begin
			excK = modelMem[zero - lag - 1]; // exc[-(lag+1)]
			for (int j = SubframeLen - 1; j >= 1; j--)
			begin
				term = highPart(shlSat(dblProd(excK, modelMem[hBase + j]), normCorrPkg::ConvShift));
				modelExcf[j] = addSat16(term, modelExcf[j - 1]);
			end
			modelExcf[0] = excK;
		end
	end
endtask

`endif

/* verification/normCorrTb.sv */
`timescale 1ns/1ns

module normCorrTb;

	localparam int SubframeLen = 40;
	localparam int ClkPeriod = 40;
	localparam int DriveDelay = 4;
	localparam int TotalLags = 35; // 1 + 11 + 3 + 10 + 5 + 5
	localparam int LoadWords = 2 * 512 + 82 + 89;
	localparam int WatchdogCycles = 2000 * TotalLags + LoadWords + 100;

	logic clk;
	logic reset;
	logic loadValid;
	normCorrPkg::memReq_t loadReq;
	logic start;
	normCorrPkg::lag_t tMin;
	normCorrPkg::lag_t tMax;
	logic resReady;
	logic loadReady;
	logic busy;
	logic resValid;
	normCorrPkg::lagResult_t result;

	int seed = 6;
	int errorCount;
	int testsRun;
	int testErrors;
	string testName;
	bit randomStall;
	bit expectSat;
	bit expAvail;
	bit expLast;
	normCorrPkg::lagResult_t expHead;

	`include "normCorrModel.svh"

	normCorrTop #(.SubframeLen(SubframeLen)) DUT (
		.clk, .reset, .loadValid, .loadReq, .start, .tMin, .tMax, .resReady,
		.loadReady, .busy, .resValid, .result
	);

	always #(ClkPeriod / 2) clk = ~clk;

	// Consumer side, optionally stalling
	always
	begin
		@(posedge clk);
		#DriveDelay;
		if (randomStall)
			resReady = ($random(seed) & 1) != 0;
		else
			resReady = 1'b1;
	end

	function automatic void refreshHead();
		expAvail = expected.size() > 0;
		expLast = expected.size() == 1;
		if (expAvail)
			expHead = expected[0];
	endfunction

	always @(posedge clk)
	begin
		if (!reset && resValid && resReady && expected.size() > 0)
		begin
			void'(expected.pop_front());
			refreshHead();
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////
	task automatic reportMismatch(bit avail, normCorrPkg::lagResult_t expVal,
		normCorrPkg::lagResult_t actVal);
		errorCount++;
		if (!avail)
			$display("Extra result for lag %0d in test %s, none was due", actVal.lag, testName);
		else
			$display("** Error: %s expected lag %0d corr %0d energy %0d, actual lag %0d corr %0d energy %0d",
				testName, expVal.lag, expVal.corr, expVal.energy,
				actVal.lag, actVal.corr, actVal.energy);
	endtask

	resultMatches: assert property (@(posedge clk) disable iff (reset)
		(resValid && resReady) |-> (expAvail && result == expHead))
		else reportMismatch($sampled(expAvail), $sampled(expHead), $sampled(result));

	resultHolds: assert property (@(posedge clk) disable iff (reset)
		(resValid && !resReady) |=> (resValid && $stable(result)))
	else
	begin
		errorCount++;
		$display("Result changed or vanished while stalled in test %s", testName);
	end

	energySaturates: assert property (@(posedge clk) disable iff (reset)
		(resValid && resReady && expectSat) |-> result.energy == 32'h7FFF_FFFF)
	else
	begin
		errorCount++;
		$display("** Error: %s expected energy %0d, actual %0d", testName,
			32'h7FFF_FFFF, $sampled(result.energy));
	end

	loadFollowsBusy: assert property (@(posedge clk) disable iff (reset) loadReady == !busy)
	else
	begin
		errorCount++;
		$display("** Error: %s expected loadReady %b, actual %b", testName,
			!$sampled(busy), $sampled(loadReady));
	end

	busyRises: assert property (@(posedge clk) disable iff (reset) (start && !busy) |=> busy)
	else
	begin
		errorCount++;
		$display("Run did not go busy after a start in test %s", testName);
	end

	busyHolds: assert property (@(posedge clk) disable iff (reset) (start && busy) |=> busy)
	else
	begin
		errorCount++;
		$display("Start while busy disturbed the run in test %s", testName);
	end

	busyFalls: assert property (@(posedge clk) disable iff (reset)
		(resValid && resReady && expLast) |=> !busy)
	else
	begin
		errorCount++;
		$display("Still busy after the last result in test %s", testName);
	end

	allDelivered: assert property (@(posedge clk) disable iff (reset) $fell(busy) |-> !expAvail)
	else
	begin
		errorCount++;
		$display("Run ended with results missing in test %s", testName);
	end

	quietAfterReset: assert property (@(posedge clk) $fell(reset) |-> (!resValid && !busy))
	else
	begin
		errorCount++;
		$display("Outputs active right after reset");
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	task automatic loadWord(input int addr, input int value);
		loadValid = 1'b1;
		loadReq = '{normCorrPkg::memAddr_t'(addr), normCorrPkg::sample_t'(value), 1'b1};
		while (!loadReady)
		begin
			@(posedge clk);
			#DriveDelay;
		end
		@(posedge clk);
		#DriveDelay;
		loadValid = 1'b0;
		modelMem[addr] = longint'(normCorrPkg::sample_t'(value));
	endtask

	task automatic fillMemory();
		int value;
		for (int a = 0; a < 512; a++)
		begin
			if (a >= normCorrPkg::HBase && a < normCorrPkg::HBase + 64)
				value = $random(seed) % 1024; // Smaller taps keep most sums unsaturated
			else
				value = $random(seed) % 2048;
			loadWord(a, value);
		end
	endtask

	// Called and returns a drive delay after a rising edge
	task automatic runLags(input int first, input int last, input bit intrude);
		int cycles;
		predictRun(first, last);
		refreshHead();
		start = 1'b1;
		tMin = normCorrPkg::lag_t'(first);
		tMax = normCorrPkg::lag_t'(last);
		@(posedge clk);
		#DriveDelay;
		start = 1'b0;
		cycles = 0;
		while (busy)
		begin
			@(posedge clk);
			#DriveDelay;
			cycles++;
			start = intrude && (cycles == 200); // Mid convolution
			if (start)
			begin
				tMin = 8'd40;
				tMax = 8'd41;
			end
		end
		start = 1'b0;
		repeat (2)
		begin
			@(posedge clk);
			#DriveDelay;
		end
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrors = errorCount;
	endtask

	task automatic finishTest();
		testsRun++;
		$display("Test %s finished with %0d errors", testName, errorCount - testErrors);
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		loadValid = 1'b0;
		loadReq = '0;
		start = 1'b0;
		tMin = '0;
		tMax = '0;
		resReady = 1'b0;
		randomStall = 1'b0;
		expectSat = 1'b0;
		errorCount = 0;
		testsRun = 0;
		testName = "reset";
		refreshHead();
		repeat (8) @(posedge clk);
		#DriveDelay;
		reset = 1'b0;

		startTest("singleLag");
		fillMemory();
		runLags(25, 25, 1'b0);
		finishTest();

		startTest("lagRange");
		runLags(20, 30, 1'b0);
		finishTest();

		startTest("energySat");
		for (int a = normCorrPkg::ExcZero - 12; a < normCorrPkg::ExcZero - 10 + SubframeLen; a++)
			loadWord(a, 32767);
		for (int a = 0; a < SubframeLen; a++)
			loadWord(normCorrPkg::HBase + a, 32767);
		expectSat = 1'b1;
		runLags(10, 12, 1'b0);
		expectSat = 1'b0;
		finishTest();

		startTest("backPressure");
		fillMemory();
		randomStall = 1'b1;
		runLags(15, 24, 1'b0);
		randomStall = 1'b0;
		finishTest();

		startTest("startWhileBusy");
		runLags(5, 9, 1'b1);
		for (int a = 0; a < SubframeLen; a++)
			loadWord(normCorrPkg::XnBase + a, $random(seed) % 2048);
		for (int a = normCorrPkg::ExcZero - 9; a < normCorrPkg::ExcZero + SubframeLen; a++)
			loadWord(a, $random(seed) % 2048);
		runLags(5, 9, 1'b0);
		finishTest();

		$display("Tests run %0d, errors %0d", testsRun, errorCount);
		if (errorCount == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Bound from the lag count and the load traffic
	initial
	begin
		#(WatchdogCycles * ClkPeriod);
		$display("Watchdog expired after %0d cycles in test %s", WatchdogCycles, testName);
		$display("Checks failed");
		$finish;
	end

endmodule

/* rtl/normCorrTop.sv */
`timescale 1ns/1ns

module normCorrTop #(
	parameter int SubframeLen = 40
) (
	input  logic clk,
	input  logic reset,
	input  logic loadValid,
	input  normCorrPkg::memReq_t loadReq,
	input  logic start,
	input  normCorrPkg::lag_t tMin,
	input  normCorrPkg::lag_t tMax,
	input  logic resReady,
	output logic loadReady,
	output logic busy,
	output logic resValid,
	output normCorrPkg::lagResult_t result
);
	//////////////////////////////////////////////////
	// Memory client buses
	//////////////////////////////////////////////////
	normCorrPkg::memReq_t convReq, corrReq, updReq;
	logic convValid, corrValid, updValid;
	logic convReady, corrReady, updReady;
	logic convRdValid, corrRdValid, updRdValid;
	normCorrPkg::sample_t rdData;

	logic convGo, corrGo, updGo;
	logic convDone, corrDone, updDone;
	normCorrPkg::memAddr_t excOrigin, excAddr;
	normCorrPkg::acc_t corr, energy;

	sampleStore store (
		.clk, .reset, .busy, .loadValid, .loadReq,
		.convValid, .corrValid, .updValid, .convReq, .corrReq, .updReq,
		.loadReady, .convReady, .corrReady, .updReady,
		.rdData, .convRdValid, .corrRdValid, .updRdValid
	);

	excConvolver #(.SubframeLen(SubframeLen)) convolver (
		.clk, .reset, .go(convGo), .excOrigin, .reqReady(convReady),
		.rdValid(convRdValid), .rdData, .reqValid(convValid), .req(convReq), .done(convDone)
	);

	lagCorrelator #(.SubframeLen(SubframeLen)) correlator (
		.clk, .reset, .go(corrGo), .reqReady(corrReady), .rdValid(corrRdValid), .rdData,
		.reqValid(corrValid), .req(corrReq), .done(corrDone), .corr, .energy
	);

	excfUpdater #(.SubframeLen(SubframeLen)) updater (
		.clk, .reset, .go(updGo), .excAddr, .reqReady(updReady),
		.rdValid(updRdValid), .rdData, .reqValid(updValid), .req(updReq), .done(updDone)
	);

	lagSequencer sequencer (
		.clk, .reset, .start, .tMin, .tMax, .convDone, .corrDone, .updDone,
		.corr, .energy, .resReady, .busy, .convGo, .corrGo, .updGo,
		.excOrigin, .excAddr, .resValid, .result
	);

endmodule

/* rtl/lagSequencer.sv */
`timescale 1ns/1ns

module lagSequencer (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  normCorrPkg::lag_t tMin,
	input  normCorrPkg::lag_t tMax,
	input  logic convDone,
	input  logic corrDone,
	input  logic updDone,
	input  normCorrPkg::acc_t corr,
	input  normCorrPkg::acc_t energy,
	input  logic resReady,
	output logic busy,
	output logic convGo,
	output logic corrGo,
	output logic updGo,
	output normCorrPkg::memAddr_t excOrigin,
	output normCorrPkg::memAddr_t excAddr,
	output logic resValid,
	output normCorrPkg::lagResult_t result
);
	normCorrPkg::seqState_e state;
	normCorrPkg::lag_t tMinR;
	normCorrPkg::lag_t tMaxR;
	normCorrPkg::lag_t lag; // Lag in progress

	assign busy = (state != normCorrPkg::SeqIdle);
	assign excOrigin = normCorrPkg::ExcZero - normCorrPkg::memAddr_t'(tMinR); // &exc[-tMin]
	assign excAddr = normCorrPkg::ExcZero - normCorrPkg::memAddr_t'(lag) - 9'd1;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= normCorrPkg::SeqIdle;
			convGo <= 1'b0;
			corrGo <= 1'b0;
			updGo <= 1'b0;
			resValid <= 1'b0;
			tMinR <= '0;
			tMaxR <= '0;
			lag <= '0;
		end
		else
		begin
			convGo <= 1'b0;
			corrGo <= 1'b0;
			updGo <= 1'b0;
			case (state)
				normCorrPkg::SeqIdle:
					if (start)
					begin
						tMinR <= tMin;
						tMaxR <= tMax;
						lag <= tMin;
						convGo <= 1'b1;
						state <= normCorrPkg::SeqConv;
					end
				normCorrPkg::SeqConv:
					if (convDone)
					begin
						corrGo <= 1'b1;
						state <= normCorrPkg::SeqCorr;
					end
				normCorrPkg::SeqCorr:
					if (corrDone)
					begin
						result <= '{lag, corr, energy};
						resValid <= 1'b1;
						state <= normCorrPkg::SeqPresent;
					end
				normCorrPkg::SeqPresent:
					if (resReady) // Held here under back-pressure
					begin
						resValid <= 1'b0;
						if (lag == tMaxR)
							state <= normCorrPkg::SeqIdle;
						else
						begin
							updGo <= 1'b1;
							state <= normCorrPkg::SeqUpdate;
						end
					end
				normCorrPkg::SeqUpdate:
					if (updDone)
					begin
						lag <= lag + 8'd1;
						corrGo <= 1'b1;
						state <= normCorrPkg::SeqCorr;
					end
				default: state <= normCorrPkg::SeqIdle;
			endcase
		end
	end

endmodule

/* rtl/excfUpdater.sv */
`timescale 1ns/1ns

module excfUpdater #(
	parameter int SubframeLen = 40
) (
	input  logic clk,
	input  logic reset,
	input  logic go,
	input  normCorrPkg::memAddr_t excAddr,
	input  logic reqReady,
	input  logic rdValid,
	input  normCorrPkg::sample_t rdData,
	output logic reqValid,
	output normCorrPkg::memReq_t req,
	output logic done
);
	localparam logic [5:0] LastJ = 6'(SubframeLen - 1);

	normCorrPkg::updState_e state;
	logic [5:0] j; // Walks down to 1
	normCorrPkg::memAddr_t kAddr;
	normCorrPkg::sample_t excK;
	normCorrPkg::acc_t prod;
	normCorrPkg::sample_t newVal;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= normCorrPkg::UpdIdle;
			done <= 1'b0;
			j <= '0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				normCorrPkg::UpdIdle:
					if (go)
					begin
						kAddr <= excAddr;
						state <= normCorrPkg::UpdReadExc;
					end
				normCorrPkg::UpdReadExc:
					if (reqReady)
						state <= normCorrPkg::UpdWaitExc;
				normCorrPkg::UpdWaitExc:
					if (rdValid)
					begin
						excK <= rdData;
						j <= LastJ;
						state <= normCorrPkg::UpdReadH;
					end
				normCorrPkg::UpdReadH:
					if (reqReady)
						state <= normCorrPkg::UpdWaitH;
				normCorrPkg::UpdWaitH:
					if (rdValid)
					begin
						prod <= normCorrPkg::lShl(normCorrPkg::lMult(excK, rdData),
							normCorrPkg::ConvShift);
						state <= normCorrPkg::UpdReadPrev;
					end
				normCorrPkg::UpdReadPrev:
					if (reqReady)
						state <= normCorrPkg::UpdWaitPrev;
				normCorrPkg::UpdWaitPrev:
					if (rdValid)
					begin
						newVal <= normCorrPkg::addSat(normCorrPkg::extractH(prod), rdData);
						state <= normCorrPkg::UpdWrite;
					end
				normCorrPkg::UpdWrite:
					if (reqReady)
					begin
						if (j == 6'd1)
							state <= normCorrPkg::UpdWriteZero;
						else
						begin
							j <= j - 6'd1;
							state <= normCorrPkg::UpdReadH;
						end
					end
				normCorrPkg::UpdWriteZero:
					if (reqReady)
					begin
						done <= 1'b1;
						state <= normCorrPkg::UpdIdle;
					end
				default: state <= normCorrPkg::UpdIdle;
			endcase
		end
	end

	always_comb
	begin
		reqValid = 1'b1;
		req = '0;
		case (state)
			normCorrPkg::UpdReadExc: req.addr = kAddr;
			normCorrPkg::UpdReadH: req.addr = normCorrPkg::HBase + normCorrPkg::memAddr_t'(j);
			normCorrPkg::UpdReadPrev:
				req.addr = normCorrPkg::ExcfBase + normCorrPkg::memAddr_t'(j - 6'd1);
			normCorrPkg::UpdWrite:
				req = '{normCorrPkg::ExcfBase + normCorrPkg::memAddr_t'(j), newVal, 1'b1};
			normCorrPkg::UpdWriteZero: req = '{normCorrPkg::ExcfBase, excK, 1'b1};
			default: reqValid = 1'b0;
		endcase
	end

endmodule

/* rtl/lagCorrelator.sv */
`timescale 1ns/1ns

module lagCorrelator #(
	parameter int SubframeLen = 40
) (
	input  logic clk,
	input  logic reset,
	input  logic go,
	input  logic reqReady,
	input  logic rdValid,
	input  normCorrPkg::sample_t rdData,
	output logic reqValid,
	output normCorrPkg::memReq_t req,
	output logic done,
	output normCorrPkg::acc_t corr,
	output normCorrPkg::acc_t energy
);
	localparam logic [5:0] LastJ = 6'(SubframeLen - 1);

	normCorrPkg::corrState_e state;
	logic [5:0] j;
	normCorrPkg::sample_t excfVal;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= normCorrPkg::CorrIdle;
			done <= 1'b0;
			j <= '0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				normCorrPkg::CorrIdle:
					if (go)
					begin
						j <= '0;
						corr <= '0;
						energy <= '0;
						state <= normCorrPkg::CorrReadExcf;
					end
				normCorrPkg::CorrReadExcf:
					if (reqReady)
						state <= normCorrPkg::CorrWaitExcf;
				normCorrPkg::CorrWaitExcf:
					if (rdValid)
					begin
						excfVal <= rdData;
						state <= normCorrPkg::CorrReadXn;
					end
				normCorrPkg::CorrReadXn:
					if (reqReady)
						state <= normCorrPkg::CorrWaitXn;
				normCorrPkg::CorrWaitXn:
					if (rdValid)
					begin
						// Both sums step together, rdData is xn[j]
						energy <= normCorrPkg::lMac(energy, excfVal, excfVal);
						corr <= normCorrPkg::lMac(corr, rdData, excfVal);
						if (j == LastJ)
						begin
							done <= 1'b1;
							state <= normCorrPkg::CorrIdle;
						end
						else
						begin
							j <= j + 6'd1;
							state <= normCorrPkg::CorrReadExcf;
						end
					end
				default: state <= normCorrPkg::CorrIdle;
			endcase
		end
	end

	always_comb
	begin
		reqValid = 1'b0;
		req = '0;
		if (state == normCorrPkg::CorrReadExcf)
		begin
			reqValid = 1'b1;
			req.addr = normCorrPkg::ExcfBase + normCorrPkg::memAddr_t'(j);
		end
		else if (state == normCorrPkg::CorrReadXn)
		begin
			reqValid = 1'b1;
			req.addr = normCorrPkg::XnBase + normCorrPkg::memAddr_t'(j);
		end
	end

endmodule

/* rtl/excConvolver.sv */
`timescale 1ns/1ns

module excConvolver #(
	parameter int SubframeLen = 40
) (
	input  logic clk,
	input  logic reset,
	input  logic go,
	input  normCorrPkg::memAddr_t excOrigin,
	input  logic reqReady,
	input  logic rdValid,
	input  normCorrPkg::sample_t rdData,
	output logic reqValid,
	output normCorrPkg::memReq_t req,
	output logic done
);
	localparam logic [5:0] LastN = 6'(SubframeLen - 1);

	normCorrPkg::convState_e state;
	logic [5:0] n; // Output sample
	logic [5:0] i; // Tap
	normCorrPkg::memAddr_t origin;
	normCorrPkg::sample_t xVal;
	normCorrPkg::acc_t sum;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= normCorrPkg::ConvIdle;
			done <= 1'b0;
			n <= '0;
			i <= '0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				normCorrPkg::ConvIdle:
					if (go)
					begin
						origin <= excOrigin;
						n <= '0;
						i <= '0;
						sum <= '0;
						state <= normCorrPkg::ConvReadX;
					end
				normCorrPkg::ConvReadX:
					if (reqReady)
						state <= normCorrPkg::ConvWaitX;
				normCorrPkg::ConvWaitX:
					if (rdValid)
					begin
						xVal <= rdData;
						state <= normCorrPkg::ConvReadH;
					end
				normCorrPkg::ConvReadH:
					if (reqReady)
						state <= normCorrPkg::ConvWaitH;
				normCorrPkg::ConvWaitH:
					if (rdValid)
					begin
						sum <= normCorrPkg::lMac(sum, xVal, rdData); // x[i] * h[n-i]
						if (i == n)
							state <= normCorrPkg::ConvWrite;
						else
						begin
							i <= i + 6'd1;
							state <= normCorrPkg::ConvReadX;
						end
					end
				normCorrPkg::ConvWrite:
					if (reqReady)
					begin
						if (n == LastN)
						begin
							done <= 1'b1;
							state <= normCorrPkg::ConvIdle;
						end
						else
						begin
							n <= n + 6'd1;
							i <= '0;
							sum <= '0;
							state <= normCorrPkg::ConvReadX;
						end
					end
				default: state <= normCorrPkg::ConvIdle;
			endcase
		end
	end

	always_comb
	begin
		reqValid = 1'b0;
		req = '0;
		case (state)
			normCorrPkg::ConvReadX:
			begin
				reqValid = 1'b1;
				req.addr = origin + normCorrPkg::memAddr_t'(i);
			end
			normCorrPkg::ConvReadH:
			begin
				reqValid = 1'b1;
				req.addr = normCorrPkg::HBase + normCorrPkg::memAddr_t'(n - i);
			end
			normCorrPkg::ConvWrite:
			begin
				reqValid = 1'b1;
				req.addr = normCorrPkg::ExcfBase + normCorrPkg::memAddr_t'(n);
				req.wrData = normCorrPkg::extractH(normCorrPkg::lShl(sum, normCorrPkg::ConvShift));
				req.write = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

/* rtl/sampleStore.sv */
`timescale 1ns/1ns

module sampleStore (
	input  logic clk,
	input  logic reset,
	input  logic busy,
	input  logic loadValid,
	input  normCorrPkg::memReq_t loadReq,
	input  logic convValid,
	input  logic corrValid,
	input  logic updValid,
	input  normCorrPkg::memReq_t convReq,
	input  normCorrPkg::memReq_t corrReq,
	input  normCorrPkg::memReq_t updReq,
	output logic loadReady,
	output logic convReady,
	output logic corrReady,
	output logic updReady,
	output normCorrPkg::sample_t rdData,
	output logic convRdValid,
	output logic corrRdValid,
	output logic updRdValid
);
	normCorrPkg::sample_t mem [0:normCorrPkg::MemDepth-1];
	normCorrPkg::memReq_t selReq;
	logic selValid;

	// Fixed priority, load first and refused during a run
	assign loadReady = !busy;
	assign convReady = !(loadValid && loadReady);
	assign corrReady = convReady && !convValid;
	assign updReady = corrReady && !corrValid;

	always_comb
	begin
		selValid = 1'b1;
		if (loadValid && loadReady)
			selReq = loadReq;
		else if (convValid)
			selReq = convReq;
		else if (corrValid)
			selReq = corrReq;
		else
		begin
			selReq = updReq;
			selValid = updValid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (selValid && selReq.write)
			mem[selReq.addr] <= selReq.wrData;
		if (selValid && !selReq.write)
			rdData <= mem[selReq.addr]; // One cycle read latency
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			convRdValid <= 1'b0;
			corrRdValid <= 1'b0;
			updRdValid <= 1'b0;
		end
		else
		begin
			convRdValid <= convValid && convReady && !convReq.write;
			corrRdValid <= corrValid && corrReady && !corrReq.write;
			updRdValid <= updValid && updReady && !updReq.write;
		end
	end

endmodule

/* rtl/normCorrPkg.sv */
package normCorrPkg;

	//////////////////////////////////////////////////
	// Widths and memory layout
	//////////////////////////////////////////////////
	typedef logic signed [15:0] sample_t; // Q15 sample
	typedef logic signed [31:0] acc_t;
	typedef logic [8:0] memAddr_t;
	typedef logic [7:0] lag_t;

	localparam int MemDepth = 512;
	localparam memAddr_t ExcZero = 9'd160; // exc[0], negative lags below
	localparam memAddr_t HBase = 9'd256;
	localparam memAddr_t XnBase = 9'd320;
	localparam memAddr_t ExcfBase = 9'd384;
	localparam int unsigned ConvShift = 3; // Q12 to Q15

	localparam acc_t MaxAcc = 32'h7FFF_FFFF;
	localparam acc_t MinAcc = 32'h8000_0000;
	localparam sample_t MaxSample = 16'h7FFF;
	localparam sample_t MinSample = 16'h8000;

	typedef struct packed {
		memAddr_t addr;
		sample_t wrData;
		logic write;
	} memReq_t;

	typedef struct packed {
		lag_t lag;
		acc_t corr;
		acc_t energy;
	} lagResult_t;

	typedef enum logic [2:0] {ConvIdle, ConvReadX, ConvWaitX, ConvReadH, ConvWaitH,
		ConvWrite} convState_e;
	typedef enum logic [2:0] {CorrIdle, CorrReadExcf, CorrWaitExcf, CorrReadXn,
		CorrWaitXn} corrState_e;
	typedef enum logic [3:0] {UpdIdle, UpdReadExc, UpdWaitExc, UpdReadH, UpdWaitH,
		UpdReadPrev, UpdWaitPrev, UpdWrite, UpdWriteZero} updState_e;
	typedef enum logic [2:0] {SeqIdle, SeqConv, SeqCorr, SeqPresent, SeqUpdate} seqState_e;

	//////////////////////////////////////////////////
	// Saturating fixed-point operators
	//////////////////////////////////////////////////
	function automatic acc_t lMult(sample_t a, sample_t b);
		acc_t prod;
		prod = a * b;
		if (prod == 32'sh4000_0000) // Only -1 * -1 overflows
			return MaxAcc;
		return prod <<< 1;
	endfunction

	function automatic acc_t lMac(acc_t acc, sample_t a, sample_t b);
		logic signed [32:0] sum;
		sum = acc + lMult(a, b);
		if (sum > MaxAcc)
			return MaxAcc;
		if (sum < MinAcc)
			return MinAcc;
		return acc_t'(sum[31:0]);
	endfunction

	function automatic acc_t lShl(acc_t x, int unsigned n);
		logic signed [63:0] wide;
		wide = x;
		wide = wide <<< n;
		if (wide > MaxAcc)
			return MaxAcc;
		if (wide < MinAcc)
			return MinAcc;
		return acc_t'(wide[31:0]);
	endfunction

	function automatic sample_t extractH(acc_t x);
		return sample_t'(x[31:16]);
	endfunction

	function automatic sample_t addSat(sample_t a, sample_t b);
		logic signed [16:0] sum;
		sum = a + b;
		if (sum > MaxSample)
			return MaxSample;
		if (sum < MinSample)
			return MinSample;
		return sample_t'(sum[15:0]);
	endfunction

endpackage
